//--- decodeIf.sv
`timescale 1ns/10ps
`default_nettype none

// Decoded operands from instDecode towards execUnit
// All purely combinational from inst and current state
interface decodeIf;

    // Instruction class
    rvCorePkg::instKindT kind;
    // Immediate, already sign extended
    rvCorePkg::wordT     imm;
    // Value of register rs1
    rvCorePkg::wordT     rs1Data;
    // Destination register index
    rvCorePkg::regAddrT  rd;
    // Current pc
    rvCorePkg::wordT     pc;
    // Sequential next pc, pc + 4
    rvCorePkg::wordT     snpc;

    // Decode drives everything
    modport decodeSide (
        output kind, imm, rs1Data, rd, pc, snpc
    );

    // Execute only reads
    modport execSide (
        input kind, imm, rs1Data, rd, pc, snpc
    );

endinterface

`default_nettype wire

//--- execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit (
    input  wire logic            clk,
    input  wire logic            rstN,
    // Decoded operands in
    decodeIf.execSide            ex,
    // Register write back
    output logic                 wen,
    output rvCorePkg::regAddrT   waddr,
    output rvCorePkg::wordT      wdata,
    // Next pc
    output rvCorePkg::wordT      dnpc,
    output logic                 halted,
    output logic                 illegal
);

    // ----------------------------------------
    // Halt FSM
    // ----------------------------------------

    typedef enum logic {
        RUN,
        HALT
    } haltStateT;

    haltStateT state;

    // Only way out of HALT is reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= RUN;
        end else if (state == RUN && ex.kind == rvCorePkg::KIND_EBREAK) begin
            state <= HALT;
        end
    end

    assign halted = (state == HALT);

    // Flagged only while running
    assign illegal = (ex.kind == rvCorePkg::KIND_ILLEGAL) && !halted;

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    rvCorePkg::wordT sum;

    // Shared adder, addi result and jalr target
    assign sum = ex.rs1Data + ex.imm;

    always_comb begin
        if (halted) begin
            // Freeze
            dnpc = ex.pc;
        end else if (ex.kind == rvCorePkg::KIND_JALR) begin
            dnpc = {sum[rvCorePkg::XLEN-1:1], 1'b0};
        end else begin
            // addi, ebreak and illegal all step on
            dnpc = ex.snpc;
        end
    end

    // Link value for jalr, sum otherwise
    assign wdata = (ex.kind == rvCorePkg::KIND_JALR) ? ex.snpc : sum;
    assign waddr = ex.rd;

    // Halt and reset both block writes
    assign wen = rstN && !halted &&
                 (ex.kind == rvCorePkg::KIND_ADDI || ex.kind == rvCorePkg::KIND_JALR);

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // An ebreak retire leaves the core halted with writes shut off from the next cycle
    aHaltNoWrite : assert property (
        @(posedge clk) disable iff (!rstN)
        (halted || ex.kind == rvCorePkg::KIND_EBREAK) |=> (halted && !wen)
    ) else $error("register write while halted");

endmodule

`default_nettype wire

//--- instDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instDecode (
    input  wire logic            clk,
    input  wire logic            rstN,
    // Fetched instruction word
    input  rvCorePkg::wordT      inst,
    // Writeback from execUnit
    input  wire logic            wen,
    input  rvCorePkg::regAddrT   waddr,
    input  rvCorePkg::wordT      wdata,
    // Next pc from execUnit
    input  rvCorePkg::wordT      dnpc,
    // Debug register read
    input  rvCorePkg::regAddrT   dbgAddr,
    output rvCorePkg::wordT      dbgData,
    // Decoded operands out
    decodeIf.decodeSide          dec
);

    // ----------------------------------------
    // Field extraction
    // ----------------------------------------

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    rvCorePkg::regAddrT rs1;
    rvCorePkg::regAddrT rd;
    rvCorePkg::immT     immRaw;

    // Standard I-type layout
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign immRaw = inst[31:20];

    // ----------------------------------------
    // Classification
    // ----------------------------------------

    rvCorePkg::instKindT kind;

    always_comb begin
        // Opcode and funct3 first
        if (opcode == rvCorePkg::OPC_OPIMM && funct3 == rvCorePkg::F3_ADDI) begin
            kind = rvCorePkg::KIND_ADDI;
        end else if (opcode == rvCorePkg::OPC_JALR && funct3 == rvCorePkg::F3_JALR) begin
            kind = rvCorePkg::KIND_JALR;
        end else if (inst == rvCorePkg::INST_EBREAK) begin
            // Exact word match only
            kind = rvCorePkg::KIND_EBREAK;
        end else begin
            kind = rvCorePkg::KIND_ILLEGAL;
        end
    end

    // ----------------------------------------
    // Register file and pc
    // ----------------------------------------

    rvCorePkg::wordT rs1Data;
    rvCorePkg::wordT pc;
    rvCorePkg::wordT snpc;

    // Operand read always on rs1 field
    regFile uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .wen     (wen),
        .waddr   (waddr),
        .wdata   (wdata),
        .raddr   (rs1),
        .rdata   (rs1Data),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData)
    );

    progCounter uProgCounter (
        .clk  (clk),
        .rstN (rstN),
        .dnpc (dnpc),
        .pc   (pc),
        .snpc (snpc)
    );

    // ----------------------------------------
    // Outputs to execUnit
    // ----------------------------------------

    assign dec.kind    = kind;
    // Sign extension of the 12-bit immediate
    assign dec.imm     = {{(rvCorePkg::XLEN - rvCorePkg::IMM_W){immRaw[rvCorePkg::IMM_W-1]}},
                          immRaw};
    assign dec.rs1Data = rs1Data;
    assign dec.rd      = rd;
    assign dec.pc      = pc;
    assign dec.snpc    = snpc;

endmodule

`default_nettype wire

//--- progCounter.sv
`timescale 1ns/10ps
`default_nettype none

module progCounter (
    input  wire logic            clk,
    input  wire logic            rstN,
    // Next pc chosen by execUnit
    input  rvCorePkg::wordT      dnpc,
    output rvCorePkg::wordT      pc,
    output rvCorePkg::wordT      snpc
);

    // ----------------------------------------
    // PC register
    // ----------------------------------------

    rvCorePkg::wordT pcQ;

    // Loads dnpc every edge, no enable
    // Halt holding is done by execUnit feeding pc back
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcQ <= rvCorePkg::RESET_PC;
        end else begin
            pcQ <= dnpc;
        end
    end

    assign pc = pcQ;

    // Sequential successor
    assign snpc = pcQ + rvCorePkg::INST_STEP;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Edge after a reset cycle always lands on the reset vector
    aResetPc : assert property (
        @(posedge clk) !rstN |=> (pc == rvCorePkg::RESET_PC)
    ) else $error("pc not at RESET_PC after reset");

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire logic            clk,
    input  wire logic            rstN,
    // Write port, from execUnit
    input  wire logic            wen,
    input  rvCorePkg::regAddrT   waddr,
    input  rvCorePkg::wordT      wdata,
    // Operand read, rs1
    input  rvCorePkg::regAddrT   raddr,
    output rvCorePkg::wordT      rdata,
    // Debug read
    input  rvCorePkg::regAddrT   dbgAddr,
    output rvCorePkg::wordT      dbgData
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    rvCorePkg::wordT regs [rvCorePkg::NUM_REGS];

    // x0 never takes a write
    logic doWrite;
    assign doWrite = wen && (waddr != '0);

    // Whole file cleared on reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < rvCorePkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (doWrite) begin
            regs[waddr] <= wdata;
        end
    end

    // ----------------------------------------
    // Read ports
    // ----------------------------------------

    // Asynchronous reads, x0 forced to zero
    assign rdata   = (raddr == '0) ? '0 : regs[raddr];

    // Write shows up here the cycle after its edge
    assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Value held in x0 stays zero out of reset, even after write attempts to it
    aZeroReg : assert property (
        @(posedge clk) disable iff (!rstN)
        (regs[0] == '0)
    ) else $error("x0 storage overwritten");

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module rvCoreTb -f rvCore.f -o rvCoreSim

status=0
./obj_dir/rvCoreSim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

//--- rvCore.f
rvCorePkg.sv
decodeIf.sv
progCounter.sv
regFile.sv
instDecode.sv
execUnit.sv
rvCoreTop.sv
rvCoreTb.sv

//--- rvCorePkg.sv
`default_nettype none

package rvCorePkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Data path and address width
    localparam int XLEN     = 32;
    // Register index width
    localparam int REG_AW   = 5;
    // Raw I-type immediate width
    localparam int IMM_W    = 12;
    // Architectural register count
    localparam int NUM_REGS = 32;

    // Data word or byte address
    typedef logic [XLEN-1:0]   wordT;
    // Register index, x0..x31
    typedef logic [REG_AW-1:0] regAddrT;
    // Immediate as found in inst[31:20]
    typedef logic [IMM_W-1:0]  immT;
    // Instruction class from decode
    typedef logic [1:0]        instKindT;

    // ----------------------------------------
    // Instruction classes
    // ----------------------------------------

    localparam instKindT KIND_ADDI    = 2'd0;
    localparam instKindT KIND_JALR    = 2'd1;
    localparam instKindT KIND_EBREAK  = 2'd2;
    // Anything else, skipped without a write
    localparam instKindT KIND_ILLEGAL = 2'd3;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------

    // OP-IMM major opcode, addi lives here
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    // JALR major opcode
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    // funct3 for addi
    localparam logic [2:0] F3_ADDI = 3'b000;
    // funct3 for jalr, the only legal one
    localparam logic [2:0] F3_JALR = 3'b000;

    // ebreak is matched on the whole word
    localparam wordT INST_EBREAK = 32'h0010_0073;

    // ----------------------------------------
    // Program counter
    // ----------------------------------------

    // Fetch address after reset
    localparam wordT RESET_PC  = 32'h8000_0000;
    // Step to the sequential instruction
    localparam wordT INST_STEP = 32'd4;

endpackage

`default_nettype wire

//--- rvCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb;

    // ----------------------------------------
    // Run length and timing
    // ----------------------------------------

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    // Nops right after reset, one per register on the debug port
    localparam int SWEEP_CYCLES = 32;
    localparam int RAND_CYCLES  = 400;
    // ebreak may only show up from here on
    localparam int HALT_START   = 360;
    // ebreak forced here if none came by chance
    localparam int HALT_FORCE   = 380;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + SWEEP_CYCLES + RAND_CYCLES) * CLK_PERIOD * 2;
    localparam logic [31:0] SEED = 32'hfde0_56d9;

    // DUT signals
    logic               clk;
    logic               rstN;
    rvCorePkg::wordT    inst;
    rvCorePkg::regAddrT dbgAddr;
    rvCorePkg::wordT    pc;
    logic               halted;
    logic               illegal;
    rvCorePkg::wordT    dbgData;

    // Reference model state
    rvCorePkg::wordT    modelRegs [rvCorePkg::NUM_REGS];
    rvCorePkg::wordT    modelPc;
    logic               modelHalted;

    rvCorePkg::regAddrT sweepAddr;
    // Name of the instruction whose effects are checked next
    string              prevName;
    int                 checkCount;
    int                 errorCount;

    rvCoreTop DUT (
        .clk     (clk),
        .rstN    (rstN),
        .inst    (inst),
        .dbgAddr (dbgAddr),
        .pc      (pc),
        .halted  (halted),
        .illegal (illegal),
        .dbgData (dbgData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // Encoding helpers
    // ----------------------------------------

    // I-type layout, imm | rs1 | funct3 | rd | opcode
    function automatic rvCorePkg::wordT encodeIType(input rvCorePkg::immT imm,
            input rvCorePkg::regAddrT rs1, input logic [2:0] f3,
            input rvCorePkg::regAddrT rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rvCorePkg::wordT signExtend(input rvCorePkg::immT imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic checkWord(input string name, input rvCorePkg::wordT exp,
            input rvCorePkg::wordT act);
        checkCount++;
        if (exp !== act) begin
            errorCount++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // ----------------------------------------
    // One instruction per cycle
    // ----------------------------------------

    // Entered at edge + 1 ns, left at the next edge + 1 ns
    task automatic runCycle(input rvCorePkg::wordT word, input rvCorePkg::instKindT kind,
            input rvCorePkg::regAddrT rd, input rvCorePkg::regAddrT rs1,
            input rvCorePkg::wordT imm, input string name);
        rvCorePkg::wordT target;
        logic            expIllegal;
        inst      = word;
        dbgAddr   = sweepAddr;
        sweepAddr = sweepAddr + 5'd1;
        // Mid cycle, state from the last edge is stable
        #49;
        checkWord({prevName, " pc"}, modelPc, pc);
        checkWord({prevName, " halted"}, {31'b0, modelHalted}, {31'b0, halted});
        checkWord($sformatf("%s x%0d", prevName, dbgAddr), modelRegs[dbgAddr], dbgData);
        expIllegal = (kind == rvCorePkg::KIND_ILLEGAL) && !modelHalted;
        checkWord({name, " illegal"}, {31'b0, expIllegal}, {31'b0, illegal});
        // Retire in the model, halted core does nothing
        if (!modelHalted) begin
            case (kind)
                rvCorePkg::KIND_ADDI: begin
                    if (rd != 5'd0) begin
                        modelRegs[rd] = modelRegs[rs1] + imm;
                    end
                    modelPc = modelPc + 32'd4;
                end
                rvCorePkg::KIND_JALR: begin
                    // Target from old rs1, rd may equal rs1
                    target = modelRegs[rs1] + imm;
                    if (rd != 5'd0) begin
                        modelRegs[rd] = modelPc + 32'd4;
                    end
                    modelPc = target & ~32'd1;
                end
                rvCorePkg::KIND_EBREAK: begin
                    modelHalted = 1'b1;
                    modelPc     = modelPc + 32'd4;
                end
                default: begin
                    modelPc = modelPc + 32'd4;
                end
            endcase
        end
        prevName = name;
        @(posedge clk);
        #1;
    endtask

    // Weighted mix, ebreak only late in the run
    task automatic runRandom(input int cycle);
        int                  pick;
        rvCorePkg::regAddrT  rd;
        rvCorePkg::regAddrT  rs1;
        rvCorePkg::immT      immRaw;
        rvCorePkg::wordT     word;
        pick   = $urandom_range(99);
        rd     = rvCorePkg::regAddrT'($urandom_range(31));
        rs1    = rvCorePkg::regAddrT'($urandom_range(31));
        immRaw = rvCorePkg::immT'($urandom);
        if (cycle >= HALT_START && !modelHalted && (pick < 15 || cycle == HALT_FORCE)) begin
            runCycle(rvCorePkg::INST_EBREAK, rvCorePkg::KIND_EBREAK, rd, rs1, '0, "ebreak");
        end else if (pick < 75) begin
            word = encodeIType(immRaw, rs1, rvCorePkg::F3_ADDI, rd, rvCorePkg::OPC_OPIMM);
            runCycle(word, rvCorePkg::KIND_ADDI, rd, rs1, signExtend(immRaw), "addi");
        end else if (pick < 92) begin
            word = encodeIType(immRaw, rs1, rvCorePkg::F3_JALR, rd, rvCorePkg::OPC_JALR);
            runCycle(word, rvCorePkg::KIND_JALR, rd, rs1, signExtend(immRaw), "jalr");
        end else begin
            // Register-register OP opcode, not executed by this core
            word      = $urandom;
            word[6:0] = 7'b0110011;
            runCycle(word, rvCorePkg::KIND_ILLEGAL, rd, rs1, '0, "illegal");
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        rstN        = 1'b0;
        inst        = encodeIType('0, '0, rvCorePkg::F3_ADDI, '0, rvCorePkg::OPC_OPIMM);
        dbgAddr     = '0;
        sweepAddr   = '0;
        modelPc     = rvCorePkg::RESET_PC;
        modelHalted = 1'b0;
        prevName    = "reset";
        checkCount  = 0;
        errorCount  = 0;
        for (int i = 0; i < rvCorePkg::NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;
        // Nops while every register is read back once
        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            runCycle(encodeIType('0, '0, rvCorePkg::F3_ADDI, '0, rvCorePkg::OPC_OPIMM),
                     rvCorePkg::KIND_ADDI, '0, '0, '0, "reset");
        end
        for (int cycle = 0; cycle < RAND_CYCLES; cycle++) begin
            runRandom(cycle);
        end
        // Effects of the last instruction
        #49;
        checkWord({prevName, " pc"}, modelPc, pc);
        checkWord({prevName, " halted"}, {31'b0, modelHalted}, {31'b0, halted});
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog, twice the planned run time
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rvCoreTop.sv
`timescale 1ns/10ps
`default_nettype none

module rvCoreTop (
    input  wire logic            clk,
    input  wire logic            rstN,
    // Fetch port, one word per cycle
    input  rvCorePkg::wordT      inst,
    // Debug register read
    input  rvCorePkg::regAddrT   dbgAddr,
    // Address of inst
    output rvCorePkg::wordT      pc,
    output logic                 halted,
    output logic                 illegal,
    output rvCorePkg::wordT      dbgData
);

    // ----------------------------------------
    // Internal nets
    // ----------------------------------------

    // Decode to execute bundle
    decodeIf decBus ();

    // Execute back to decode
    logic               wen;
    rvCorePkg::regAddrT waddr;
    rvCorePkg::wordT    wdata;
    rvCorePkg::wordT    dnpc;

    // ----------------------------------------
    // Decode, register file and pc
    // ----------------------------------------

    instDecode uInstDecode (
        .clk     (clk),
        .rstN    (rstN),
        .inst    (inst),
        .wen     (wen),
        .waddr   (waddr),
        .wdata   (wdata),
        .dnpc    (dnpc),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData),
        .dec     (decBus.decodeSide)
    );

    // ----------------------------------------
    // Execute and halt control
    // ----------------------------------------

    execUnit uExecUnit (
        .clk     (clk),
        .rstN    (rstN),
        .ex      (decBus.execSide),
        .wen     (wen),
        .waddr   (waddr),
        .wdata   (wdata),
        .dnpc    (dnpc),
        .halted  (halted),
        .illegal (illegal)
    );

    // Fetch address straight off the decode bundle
    assign pc = decBus.pc;

endmodule

`default_nettype wire
